// ==== hw/muldiv_pkg.sv ====
//////////////////////////////
// Multiply/divide cluster package
// Widths, operation and unit encodings, and the
// structs passed between decoder, units and writeback
//////////////////////////////
package muldiv_pkg;

    localparam int XLEN      = 32;           // Operand and result width
    localparam int TAG_W     = 4;            // Request tag width
    localparam int DIV_STEPS = XLEN;         // One quotient bit per step

    // Multiplier datapath widths
    localparam int MUL_W  = XLEN + 1;        // Sign/zero extended operand
    localparam int PROD_W = 2 * MUL_W;       // Full signed product

    // Divider step counter, counts 0..DIV_STEPS
    localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);
    localparam logic [DIV_CNT_W-1:0] DIV_LAST = DIV_CNT_W'(DIV_STEPS);

    // M-extension ops, encoded as funct3
    typedef enum logic [2:0] {
        OP_MUL    = 3'b000,
        OP_MULH   = 3'b001,
        OP_MULHSU = 3'b010,
        OP_MULHU  = 3'b011,
        OP_DIV    = 3'b100,
        OP_DIVU   = 3'b101,
        OP_REM    = 3'b110,
        OP_REMU   = 3'b111
    } op_e;

    // Writeback source
    typedef enum logic {
        MUL_UNIT = 1'b0,
        DIV_UNIT = 1'b1
    } unit_e;

    typedef struct packed {
        op_e              op;
        logic [XLEN-1:0]  rs1;
        logic [XLEN-1:0]  rs2;
        logic [TAG_W-1:0] tag;
    } issue_req_t;

    typedef struct packed {
        logic             rs1_signed;
        logic             rs2_signed;
        logic             high_half;    // Upper word of product wanted
        logic [XLEN-1:0]  rs1;
        logic [XLEN-1:0]  rs2;
        logic [TAG_W-1:0] tag;
    } mul_inputs_t;

    typedef struct packed {
        logic             is_signed;
        logic             want_rem;     // REM/REMU
        logic [XLEN-1:0]  rs1;
        logic [XLEN-1:0]  rs2;
        logic [TAG_W-1:0] tag;
    } div_inputs_t;

    // Result held by a done unit
    typedef struct packed {
        logic [XLEN-1:0]  rd;
        logic [TAG_W-1:0] tag;
    } unit_wb_t;

    // Shared writeback bus
    typedef struct packed {
        logic [XLEN-1:0]  rd;
        logic [TAG_W-1:0] tag;
        unit_e            src;
    } wb_bus_t;

endpackage

// ==== hw/issue_decode.sv ====
//////////////////////////////
// Issue decoder
// Steers each request to the multiplier or divider
// and builds that unit's input struct
//////////////////////////////
`timescale 1ns/10ps

module issue_decode (
    input  logic                    issue_valid,
    input  muldiv_pkg::issue_req_t  issue_req,
    input  logic                    mul_ready,
    input  logic                    div_ready,
    output logic                    issue_ready,
    output logic                    mul_new_request,
    output muldiv_pkg::mul_inputs_t mul_inputs,
    output logic                    div_new_request,
    output muldiv_pkg::div_inputs_t div_inputs
);

    logic is_div;   // Op belongs to the divider

    assign is_div = issue_req.op inside {muldiv_pkg::OP_DIV, muldiv_pkg::OP_DIVU,
                                         muldiv_pkg::OP_REM, muldiv_pkg::OP_REMU};

    //////////////////////////////
    // Handshake
    //////////////////////////////
    assign issue_ready     = is_div ? div_ready : mul_ready;   // Owner's ready
    assign mul_new_request = issue_valid & ~is_div & mul_ready;
    assign div_new_request = issue_valid & is_div & div_ready;

    //////////////////////////////
    // Multiplier inputs
    //////////////////////////////
    // Low word of MUL is the same either way
    assign mul_inputs.rs1_signed = issue_req.op inside {muldiv_pkg::OP_MULH,
                                                        muldiv_pkg::OP_MULHSU};
    assign mul_inputs.rs2_signed = (issue_req.op == muldiv_pkg::OP_MULH);
    assign mul_inputs.high_half  = (issue_req.op != muldiv_pkg::OP_MUL);
    assign mul_inputs.rs1        = issue_req.rs1;
    assign mul_inputs.rs2        = issue_req.rs2;
    assign mul_inputs.tag        = issue_req.tag;

    //////////////////////////////
    // Divider inputs
    //////////////////////////////
    assign div_inputs.is_signed = issue_req.op inside {muldiv_pkg::OP_DIV,
                                                       muldiv_pkg::OP_REM};
    assign div_inputs.want_rem  = issue_req.op inside {muldiv_pkg::OP_REM,
                                                       muldiv_pkg::OP_REMU};
    assign div_inputs.rs1       = issue_req.rs1;
    assign div_inputs.rs2       = issue_req.rs2;
    assign div_inputs.tag       = issue_req.tag;   // Tag passes straight through

endmodule

// ==== hw/mul_unit.sv ====
//////////////////////////////
// Pipelined multiplier
// Two stages, 33x33 signed product covering all
// MUL variants, result held until accepted
//////////////////////////////
`timescale 1ns/10ps

module mul_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    new_request,
    input  muldiv_pkg::mul_inputs_t mul_inputs,
    output logic                    ready,
    output logic                    done,
    output muldiv_pkg::unit_wb_t    result,
    input  logic                    accepted
);

    logic [1:0] valid;      // Per stage valid
    logic [1:0] advance;    // Per stage load enable
    logic [1:0] high_half;  // Upper word select, per stage

    logic signed [muldiv_pkg::MUL_W-1:0]  rs1_ext;
    logic signed [muldiv_pkg::MUL_W-1:0]  rs2_ext;
    logic signed [muldiv_pkg::MUL_W-1:0]  rs1_r;
    logic signed [muldiv_pkg::MUL_W-1:0]  rs2_r;
    logic signed [muldiv_pkg::PROD_W-1:0] product;
    logic [muldiv_pkg::TAG_W-1:0]         tag0;
    logic [muldiv_pkg::TAG_W-1:0]         tag1;

    //////////////////////////////
    // Pipeline control
    //////////////////////////////
    assign advance[1] = accepted | ~valid[1];     // Output slot free
    assign advance[0] = ~valid[0] | advance[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            if (advance[0]) valid[0] <= new_request;
            if (advance[1]) valid[1] <= valid[0];
        end
    end

    // Extra top bit makes one signed multiply serve every signedness mix
    assign rs1_ext = signed'({mul_inputs.rs1_signed & mul_inputs.rs1[muldiv_pkg::XLEN-1],
                              mul_inputs.rs1});
    assign rs2_ext = signed'({mul_inputs.rs2_signed & mul_inputs.rs2[muldiv_pkg::XLEN-1],
                              mul_inputs.rs2});

    //////////////////////////////
    // Datapath
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (new_request) begin          // Only arrives when stage 0 can load
            rs1_r        <= rs1_ext;
            rs2_r        <= rs2_ext;
            high_half[0] <= mul_inputs.high_half;
            tag0         <= mul_inputs.tag;
        end
        if (advance[1]) begin
            product      <= rs1_r * rs2_r;
            high_half[1] <= high_half[0];
            tag1         <= tag0;
        end
    end

    assign ready      = accepted | ~(&valid);   // Room somewhere in the pipe
    assign done       = valid[1];
    assign result.rd  = high_half[1] ? product[2*muldiv_pkg::XLEN-1:muldiv_pkg::XLEN]
                                     : product[muldiv_pkg::XLEN-1:0];
    assign result.tag = tag1;

endmodule

// ==== hw/div_unit.sv ====
//////////////////////////////
// Iterative divider
// Radix-2 restoring divide on operand magnitudes,
// then sign fix-up and RISC-V divide-by-zero rules
//////////////////////////////
`timescale 1ns/10ps

module div_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    new_request,
    input  muldiv_pkg::div_inputs_t div_inputs,
    output logic                    ready,
    output logic                    done,
    output muldiv_pkg::unit_wb_t    result,
    input  logic                    accepted
);

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        BUSY = 2'b01,
        DONE = 2'b10
    } state_e;

    state_e                           state;
    logic [muldiv_pkg::DIV_CNT_W-1:0] count;      // Steps taken so far

    logic [muldiv_pkg::XLEN-1:0]  rs1_mag;
    logic [muldiv_pkg::XLEN-1:0]  rs2_mag;
    logic [muldiv_pkg::XLEN-1:0]  rem_r;          // Partial remainder
    logic [muldiv_pkg::XLEN-1:0]  quo_r;          // Dividend shifting out, quotient in
    logic [muldiv_pkg::XLEN-1:0]  divisor_r;
    logic [muldiv_pkg::XLEN:0]    shifted;
    logic [muldiv_pkg::XLEN:0]    diff;
    logic [muldiv_pkg::XLEN-1:0]  rem_fix;
    logic [muldiv_pkg::XLEN-1:0]  quo_fix;
    logic [muldiv_pkg::XLEN-1:0]  rd_r;
    logic [muldiv_pkg::TAG_W-1:0] tag_r;
    logic                         quo_neg;
    logic                         rem_neg;
    logic                         want_rem;
    logic                         div_zero;

    // Magnitudes of signed operands
    assign rs1_mag = (div_inputs.is_signed & div_inputs.rs1[muldiv_pkg::XLEN-1])
                   ? -div_inputs.rs1 : div_inputs.rs1;
    assign rs2_mag = (div_inputs.is_signed & div_inputs.rs2[muldiv_pkg::XLEN-1])
                   ? -div_inputs.rs2 : div_inputs.rs2;

    //////////////////////////////
    // Control
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            count <= '0;
        end else begin
            if (new_request) begin
                count <= '0;
            end else if (state == BUSY) begin
                count <= count + 1'b1;
            end
            case (state)
                IDLE: if (new_request) state <= BUSY;
                BUSY: if (count == muldiv_pkg::DIV_LAST) state <= DONE;   // Fix-up cycle
                DONE: if (accepted) state <= new_request ? BUSY : IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Shift-subtract step
    //////////////////////////////
    assign shifted = {rem_r, quo_r[muldiv_pkg::XLEN-1]};
    assign diff    = shifted - {1'b0, divisor_r};   // Top bit set means borrow

    // Sign fix-up, zero divisor forces all-ones quotient
    // Remainder of a zero divide is already the dividend
    // MIN / -1 gives quotient MIN and remainder 0 without special handling
    assign rem_fix = rem_neg ? -rem_r : rem_r;
    assign quo_fix = div_zero ? '1 : (quo_neg ? -quo_r : quo_r);

    always_ff @(posedge clk) begin
        if (new_request) begin
            rem_r     <= '0;
            quo_r     <= rs1_mag;
            divisor_r <= rs2_mag;
            quo_neg   <= div_inputs.is_signed &
                         (div_inputs.rs1[muldiv_pkg::XLEN-1] ^ div_inputs.rs2[muldiv_pkg::XLEN-1]);
            rem_neg   <= div_inputs.is_signed & div_inputs.rs1[muldiv_pkg::XLEN-1];
            want_rem  <= div_inputs.want_rem;
            div_zero  <= (div_inputs.rs2 == '0);
            tag_r     <= div_inputs.tag;
        end else if (state == BUSY) begin
            if (count == muldiv_pkg::DIV_LAST) begin
                rd_r <= want_rem ? rem_fix : quo_fix;
            end else begin
                rem_r <= diff[muldiv_pkg::XLEN] ? shifted[muldiv_pkg::XLEN-1:0]
                                                : diff[muldiv_pkg::XLEN-1:0];
                quo_r <= {quo_r[muldiv_pkg::XLEN-2:0], ~diff[muldiv_pkg::XLEN]};
            end
        end
    end

    assign ready      = (state == IDLE) | ((state == DONE) & accepted);
    assign done       = (state == DONE);
    assign result.rd  = rd_r;
    assign result.tag = tag_r;

endmodule

// ==== hw/wb_arbiter.sv ====
//////////////////////////////
// Writeback arbiter
// Round-robin grant of the shared result bus
// between the multiplier and the divider
//////////////////////////////
`timescale 1ns/10ps

module wb_arbiter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mul_done,
    input  muldiv_pkg::unit_wb_t mul_result,
    input  logic                 div_done,
    input  muldiv_pkg::unit_wb_t div_result,
    output logic                 mul_accepted,
    output logic                 div_accepted,
    output logic                 wb_valid,
    output muldiv_pkg::wb_bus_t  wb_bus
);

    muldiv_pkg::unit_e last_grant;   // Unit granted most recently

    //////////////////////////////
    // Grant
    //////////////////////////////
    // On a tie the unit not served last wins
    assign mul_accepted = mul_done & (~div_done | (last_grant == muldiv_pkg::DIV_UNIT));
    assign div_accepted = div_done & ~mul_accepted;
    assign wb_valid     = mul_done | div_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= muldiv_pkg::DIV_UNIT;   // So MUL goes first after reset
        end else if (wb_valid) begin
            last_grant <= mul_accepted ? muldiv_pkg::MUL_UNIT : muldiv_pkg::DIV_UNIT;
        end
    end

    //////////////////////////////
    // Bus mux
    //////////////////////////////
    assign wb_bus.rd  = mul_accepted ? mul_result.rd : div_result.rd;
    assign wb_bus.tag = mul_accepted ? mul_result.tag : div_result.tag;
    assign wb_bus.src = mul_accepted ? muldiv_pkg::MUL_UNIT : muldiv_pkg::DIV_UNIT;

endmodule

// ==== hw/muldiv_top.sv ====
//////////////////////////////
// Multiply/divide cluster top
// Decoder, pipelined multiplier, iterative divider
// and shared writeback arbiter
//////////////////////////////
`timescale 1ns/10ps

module muldiv_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  muldiv_pkg::issue_req_t issue_req,
    output logic                   issue_ready,
    output logic                   wb_valid,
    output muldiv_pkg::wb_bus_t    wb_bus
);

    // Issue side
    logic                    mul_ready;
    logic                    div_ready;
    logic                    mul_new_request;
    logic                    div_new_request;
    muldiv_pkg::mul_inputs_t mul_inputs;
    muldiv_pkg::div_inputs_t div_inputs;

    // Writeback side
    logic                    mul_done;
    logic                    div_done;
    logic                    mul_accepted;
    logic                    div_accepted;
    muldiv_pkg::unit_wb_t    mul_result;
    muldiv_pkg::unit_wb_t    div_result;

    issue_decode issue_decode_i (
        .issue_valid     (issue_valid),
        .issue_req       (issue_req),
        .mul_ready       (mul_ready),
        .div_ready       (div_ready),
        .issue_ready     (issue_ready),
        .mul_new_request (mul_new_request),
        .mul_inputs      (mul_inputs),
        .div_new_request (div_new_request),
        .div_inputs      (div_inputs)
    );

    mul_unit mul_unit_i (
        .clk         (clk),
        .rst         (rst),
        .new_request (mul_new_request),
        .mul_inputs  (mul_inputs),
        .ready       (mul_ready),
        .done        (mul_done),
        .result      (mul_result),
        .accepted    (mul_accepted)
    );

    div_unit div_unit_i (
        .clk         (clk),
        .rst         (rst),
        .new_request (div_new_request),
        .div_inputs  (div_inputs),
        .ready       (div_ready),
        .done        (div_done),
        .result      (div_result),
        .accepted    (div_accepted)
    );

    wb_arbiter wb_arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .mul_done     (mul_done),
        .mul_result   (mul_result),
        .div_done     (div_done),
        .div_result   (div_result),
        .mul_accepted (mul_accepted),
        .div_accepted (div_accepted),
        .wb_valid     (wb_valid),
        .wb_bus       (wb_bus)
    );

endmodule

// ==== dv/muldiv_tb.sv ====
//////////////////////////////
// Multiply/divide cluster testbench
// Directed corner and LFSR requests, tag scoreboard,
// concurrent checks on results, timing and grants
//////////////////////////////
`timescale 1ns/10ps

module muldiv_tb;

    localparam int NTAGS     = 2 ** muldiv_pkg::TAG_W;
    localparam int TOTAL_REQ = 128 + 12 + 52 + 300;     // Corner, burst, overlap, random
    localparam int WATCHDOG  = TOTAL_REQ * (muldiv_pkg::DIV_STEPS + 10);

    logic                   clk;
    logic                   rst = 1'b1;
    logic                   issue_valid = 1'b0;
    muldiv_pkg::issue_req_t issue_req = '0;
    logic                   issue_ready;
    logic                   wb_valid;
    muldiv_pkg::wb_bus_t    wb_bus;

    // Scoreboard, indexed by tag
    logic [NTAGS-1:0]             pending = '0;
    logic [muldiv_pkg::XLEN-1:0]  exp_rd_tab [NTAGS];
    muldiv_pkg::unit_e            exp_src_tab [NTAGS];
    logic [muldiv_pkg::XLEN-1:0]  exp_rd_now;
    muldiv_pkg::unit_e            exp_src_now;
    muldiv_pkg::unit_e            last_src = muldiv_pkg::DIV_UNIT;   // MUL favoured first
    int                           accepted_cnt = 0;
    int                           returned_cnt = 0;
    int                           div_out = 0;        // Divides in flight
    int                           div_cyc = 0;        // Issue cycle of the divide in flight
    int                           cycle = 0;

    // Multiplies retire in issue order
    logic [muldiv_pkg::TAG_W-1:0] mul_tag_q [NTAGS];
    int                           mul_cyc_q [NTAGS];
    logic [muldiv_pkg::TAG_W:0]   mul_wr = '0;
    logic [muldiv_pkg::TAG_W:0]   mul_rd = '0;
    logic                         mul_head_ready;     // Oldest multiply is done
    logic                         div_head_ready;     // Divide in flight is done

    logic                         is_div_req;
    logic                         req_taken;
    logic                         mul_fast;           // Multiply with no divide in flight
    logic                         div_win;
    logic                         fast_d1 = 1'b0;
    logic                         fast_d2 = 1'b0;
    logic [muldiv_pkg::TAG_W-1:0] fast_tag_d1 = '0;
    logic [muldiv_pkg::TAG_W-1:0] fast_tag_d2 = '0;
    logic                         div_win_d1 = 1'b0;
    logic                         rst_d1 = 1'b1;

    logic [31:0]                  lfsr = 32'h7d63_6bd8;
    logic [muldiv_pkg::TAG_W-1:0] next_tag = '0;

    muldiv_top muldiv_top_i (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_req   (issue_req),
        .issue_ready (issue_ready),
        .wb_valid    (wb_valid),
        .wb_bus      (wb_bus)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [31:0] model_rd(input muldiv_pkg::issue_req_t req);
        logic        [31:0] a;
        logic        [31:0] b;
        logic signed [31:0] na;
        logic signed [31:0] nb;
        logic signed [63:0] sa;
        logic        [63:0] p_ss;
        logic        [63:0] p_su;
        logic        [63:0] p_uu;
        logic               ovf;        // MIN / -1
        logic        [31:0] rd;
        a    = req.rs1;
        b    = req.rs2;
        na   = req.rs1;
        nb   = req.rs2;
        sa   = {{32{a[31]}}, a};
        p_ss = sa * $signed({{32{b[31]}}, b});
        p_su = sa * $signed({32'b0, b});
        p_uu = {32'b0, a} * {32'b0, b};
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (req.op)
            muldiv_pkg::OP_MUL:    rd = p_uu[31:0];
            muldiv_pkg::OP_MULH:   rd = p_ss[63:32];
            muldiv_pkg::OP_MULHSU: rd = p_su[63:32];
            muldiv_pkg::OP_MULHU:  rd = p_uu[63:32];
            muldiv_pkg::OP_DIV: begin
                if (b == 0) rd = '1;
                else if (ovf) rd = a;
                else rd = na / nb;
            end
            muldiv_pkg::OP_DIVU: rd = (b == 0) ? '1 : a / b;
            muldiv_pkg::OP_REM: begin
                if (b == 0) rd = a;
                else if (ovf) rd = '0;
                else rd = na % nb;
            end
            default: rd = (b == 0) ? a : a % b;   // REMU
        endcase
        return rd;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] corner_value(input logic [1:0] i);
        case (i)
            2'd0:    return 32'h0000_0000;
            2'd1:    return 32'hffff_ffff;
            2'd2:    return 32'h8000_0000;
            default: return 32'h0000_0001;
        endcase
    endfunction

    //////////////////////////////
    // Scoreboard bookkeeping
    //////////////////////////////
    assign is_div_req     = issue_req.op[2];   // funct3 1xx is DIV/REM
    assign req_taken      = issue_valid & issue_ready;
    assign mul_fast       = req_taken & ~is_div_req & (div_out == 0);
    assign div_win        = wb_valid & (wb_bus.src == muldiv_pkg::DIV_UNIT);
    assign exp_rd_now     = exp_rd_tab[wb_bus.tag];
    assign exp_src_now    = exp_src_tab[wb_bus.tag];
    assign mul_head_ready = (mul_wr != mul_rd) &&
                            (cycle >= mul_cyc_q[mul_rd[muldiv_pkg::TAG_W-1:0]] + 2);
    // Done rises DIV_STEPS+1 edges after issue and is seen one edge later
    assign div_head_ready = (div_out != 0) &&
                            (cycle >= div_cyc + muldiv_pkg::DIV_STEPS + 2);

    always @(posedge clk) begin
        cycle       <= cycle + 1;
        rst_d1      <= rst;
        fast_d1     <= mul_fast;
        fast_d2     <= fast_d1;
        fast_tag_d1 <= issue_req.tag;
        fast_tag_d2 <= fast_tag_d1;
        div_win_d1  <= div_win & mul_head_ready;    // Multiply lost a tie
    end

    always @(posedge clk) begin
        if (rst) begin
            pending  <= '0;
            last_src <= muldiv_pkg::DIV_UNIT;
            div_out  <= 0;
            mul_wr   <= '0;
            mul_rd   <= '0;
        end else begin
            if (req_taken) begin
                pending[issue_req.tag]     <= 1'b1;
                exp_rd_tab[issue_req.tag]  <= model_rd(issue_req);
                exp_src_tab[issue_req.tag] <= is_div_req ? muldiv_pkg::DIV_UNIT
                                                         : muldiv_pkg::MUL_UNIT;
                accepted_cnt               <= accepted_cnt + 1;
                if (!is_div_req) begin
                    mul_tag_q[mul_wr[muldiv_pkg::TAG_W-1:0]] <= issue_req.tag;
                    mul_cyc_q[mul_wr[muldiv_pkg::TAG_W-1:0]] <= cycle;
                    mul_wr                                   <= mul_wr + 1'b1;
                end else begin
                    div_cyc <= cycle;
                end
            end
            if (wb_valid) begin
                pending[wb_bus.tag] <= 1'b0;
                returned_cnt        <= returned_cnt + 1;
                last_src            <= exp_src_now;
                if (exp_src_now == muldiv_pkg::MUL_UNIT) mul_rd <= mul_rd + 1'b1;
            end
            div_out <= div_out + int'(req_taken & is_div_req)
                               - int'(wb_valid && exp_src_now == muldiv_pkg::DIV_UNIT);
        end
    end

    //////////////////////////////
    // Checks
    //////////////////////////////
    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    a_tag_outstanding: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> pending[wb_bus.tag])
        else stop_with_error($sformatf("result at %0t carries tag %0d that is not outstanding",
                                       $time, $sampled(wb_bus.tag)));

    a_rd: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_bus.rd == exp_rd_now)
        else stop_with_error($sformatf("error %0t wb_bus.rd: got %h, expected %h",
                                       $time, $sampled(wb_bus.rd), $sampled(exp_rd_now)));

    a_src: assert property (@(posedge clk) disable iff (rst)
        wb_valid |-> wb_bus.src == exp_src_now)
        else stop_with_error($sformatf("error %0t wb_bus.src: got %0d, expected %0d",
                                       $time, $sampled(wb_bus.src), $sampled(exp_src_now)));

    a_mul_order: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && wb_bus.src == muldiv_pkg::MUL_UNIT) |->
            wb_bus.tag == mul_tag_q[mul_rd[muldiv_pkg::TAG_W-1:0]])
        else stop_with_error($sformatf("error %0t wb_bus.tag: got %0d, expected %0d", $time,
                                       $sampled(wb_bus.tag),
                                       $sampled(mul_tag_q[mul_rd[muldiv_pkg::TAG_W-1:0]])));

    // Issue at N, on the bus at N+2
    a_mul_latency: assert property (@(posedge clk) disable iff (rst)
        fast_d2 |-> (wb_valid && wb_bus.tag == fast_tag_d2))
        else stop_with_error($sformatf("error %0t wb_bus.tag: got %0d (wb_valid %b), expected %0d",
                                       $time, $sampled(wb_bus.tag), $sampled(wb_valid),
                                       $sampled(fast_tag_d2)));

    a_mul_ready: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && !is_div_req && !div_win) |-> issue_ready)
        else stop_with_error($sformatf("error %0t issue_ready: got 0, expected 1 for a multiply",
                                       $time));

    a_div_refused: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && is_div_req && div_out != 0 && !div_win) |-> !issue_ready)
        else stop_with_error($sformatf("error %0t issue_ready: got 1, expected 0 while divider busy",
                                       $time));

    a_rr_after_div: assert property (@(posedge clk) disable iff (rst)
        div_win_d1 |-> (wb_valid && wb_bus.src == muldiv_pkg::MUL_UNIT))
        else stop_with_error($sformatf("error %0t wb_bus.src: got %0d (wb_valid %b), expected %0d",
                                       $time, $sampled(wb_bus.src), $sampled(wb_valid),
                                       muldiv_pkg::MUL_UNIT));

    // On a tie the unit not served last wins
    a_rr_tie: assert property (@(posedge clk) disable iff (rst)
        (div_head_ready && mul_head_ready) |-> (wb_valid && wb_bus.src != last_src))
        else stop_with_error($sformatf("error %0t wb_bus.src: got %0d (wb_valid %b), expected %0d",
                                       $time, $sampled(wb_bus.src), $sampled(wb_valid),
                                       !$sampled(last_src)));

    // State is unknown until the first reset edge
    a_reset_quiet: assert property (@(posedge clk)
        (cycle != 0 && (rst || rst_d1)) |-> !wb_valid)
        else stop_with_error($sformatf("error %0t wb_valid: got 1, expected 0 around reset",
                                       $time));

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic pick_operand(output logic [31:0] v);
        logic [31:0] sel;
        take_bits(2, sel);
        if (sel[1:0] == 2'b11) begin      // Mix in a corner operand
            take_bits(2, sel);
            v = corner_value(sel[1:0]);
        end else begin
            take_bits(32, v);
        end
    endtask

    // Holds the request until the DUT takes it
    task automatic send(input muldiv_pkg::op_e op, input logic [31:0] a, input logic [31:0] b);
        muldiv_pkg::issue_req_t req;
        while (pending[next_tag]) begin   // Tag still in flight
            issue_valid <= 1'b0;
            @(posedge clk);
        end
        req.op      = op;
        req.rs1     = a;
        req.rs2     = b;
        req.tag     = next_tag;
        issue_valid <= 1'b1;
        issue_req   <= req;
        do begin
            @(posedge clk);
        end while (!issue_ready);
        next_tag = next_tag + 1'b1;
    endtask

    task automatic send_mul();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] bits;
        take_bits(2, bits);
        pick_operand(a);
        pick_operand(b);
        send(muldiv_pkg::op_e'({1'b0, bits[1:0]}), a, b);
    endtask

    task automatic drain();
        issue_valid <= 1'b0;
        @(posedge clk);
        while (returned_cnt != accepted_cnt) @(posedge clk);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] bits;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        // Every op against every corner pair, includes /0 and MIN/-1
        for (int op = 0; op < 8; op++) begin
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    send(muldiv_pkg::op_e'(3'(op)), corner_value(2'(i)), corner_value(2'(j)));
                end
            end
        end
        drain();
        repeat (12) send_mul();           // Back to back, divider idle
        drain();
        // Second divide waits out the first, then muls collide with it
        pick_operand(a);
        pick_operand(b);
        send(muldiv_pkg::OP_DIV, a, b);
        repeat (10) send_mul();
        pick_operand(a);
        pick_operand(b);
        send(muldiv_pkg::OP_REMU, a, b);
        repeat (40) send_mul();
        drain();
        repeat (300) begin
            take_bits(3, bits);
            pick_operand(a);
            pick_operand(b);
            send(muldiv_pkg::op_e'(bits[2:0]), a, b);
            take_bits(2, bits);
            if (bits[1:0] == 2'b00) begin // Occasional idle cycle
                issue_valid <= 1'b0;
                @(posedge clk);
            end
        end
        drain();
        if (returned_cnt == TOTAL_REQ && pending == '0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_with_error($sformatf("only %0d of %0d results returned", returned_cnt,
                                      TOTAL_REQ));
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        stop_with_error("timeout, results still outstanding when the watchdog expired");
    end

endmodule

// ==== project.f ====
hw/muldiv_pkg.sv
hw/issue_decode.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/wb_arbiter.sv
hw/muldiv_top.sv
dv/muldiv_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the multiply/divide cluster testbench with Verilator and run it
# The result is decided by searching the simulation log

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module muldiv_tb \
    -f project.f -o muldiv_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/muldiv_sim > sim.log 2>&1 || true
cat sim.log
grep -q "=== PASS ===" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
